// ==== src.f ====
+incdir+common
common/dbg_bus_pkg.sv
common/cpu_ctl_pkg.sv
hw/dbg_skid_buffer.sv
dbg_port/dbg_axil_slave.sv
dbg_port/cpu_cmd_ctrl.sv
hw/zip_dbg_top.sv
tests/tb_clock_gen.sv
tests/tb_zip_dbg.sv

// ==== tests/tb_zip_dbg.sv ====
`timescale 1ns/100ps
`include "dbg_consts.svh"

module tb_zip_dbg;
	import dbg_bus_pkg::*;
	import cpu_ctl_pkg::*;

	// Six short tests, a few dozen cycles each, with wide margin
	localparam int CYCLE_LIMIT = 2000;
	// Command address and the select bit in byte addresses
	localparam logic [7:0] CMD_ADDR = 8'h1 << (`CTL_SEL_BIT + `DBG_LSB);
	// Break resets the core only with this clear
	localparam bit START_HALTED = 1'b0;

	logic		clk, rstn;
	logic		awvalid, awready, wvalid, wready, bvalid, bready;
	logic		arvalid, arready, rvalid, rready, interrupt;
	logic [7:0]	awaddr, araddr, reg_addr;
	logic [1:0]	bresp, rresp;
	logic [31:0]	rdata, dbg_rdata, rd_val, lcg_state, rnd;
	dbg_wbeat_t	wbeat;
	cpu_dbg_rsp_t	dbg_rsp;
	cpu_dbg_wr_t	dbg_wr, land_wr;
	logic [4:0]	dbg_rreg;
	logic		dbg_we, cpu_reset, cpu_halt, cpu_step, clear_cache;

	// Core model state
	logic [31:0]	regs [32];
	int		stall_left;
	logic		armed, brk, quiet_port, land, stall_seen;
	logic [2:0]	cc;
	logic [4:0]	exp_reg;
	logic [31:0]	exp_data;
	int		cycles, hold;

	tb_clock_gen u_clk (.o_clk(clk), .o_rstn(rstn));

	zip_dbg_top #(.START_HALTED(START_HALTED)) dut_i (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wbeat(wbeat),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
		.i_interrupt(interrupt), .i_dbg_rsp(dbg_rsp), .i_dbg_rdata(dbg_rdata),
		.o_dbg_we(dbg_we), .o_dbg_wr(dbg_wr), .o_dbg_rreg(dbg_rreg),
		.o_cpu_reset(cpu_reset), .o_cpu_halt(cpu_halt),
		.o_cpu_step(cpu_step), .o_clear_cache(clear_cache)
	);

	// LCG, numerical recipes constants
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic fail_stop();
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic report_error(string name, logic [31:0] exp, logic [31:0] act);
		$display("** Error %s: expected %h, actual %h", name, exp, act);
		fail_stop();
	endtask

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		assert (exp === act)
		else
			report_error(name, exp, act);
	endtask

	////////////////////
	// Core model
	////////////////////

	assign dbg_rsp   = {(stall_left != 0), brk, cc};
	assign dbg_rdata = regs[dbg_rreg];

	// Core side and random back-pressure on B and R
	always
	begin
		@(posedge clk);
		// Write lands at the edge where stall is low
		land = dbg_we && !dbg_rsp.stall;
		land_wr = dbg_wr;
		#1;
		if (land)
		begin
			check_eq("reg_write_regno", exp_reg, land_wr.regno);
			check_eq("reg_write_data", exp_data, land_wr.data);
			regs[land_wr.regno] = land_wr.data;
			cc = land_wr.data[2:0];
			armed = 1'b0;
		end
		if (stall_left > 0)
			stall_left = stall_left - 1;
		else if (dbg_we && !armed)
		begin
			// Random 0 to 3 stall cycles per write
			rnd = next_rand();
			stall_left = rnd[17:16];
			armed = 1'b1;
			if (stall_left != 0)
				stall_seen = 1'b1;
		end
		rnd = next_rand();
		bready = rnd[20] | rnd[21];
		rready = rnd[22] | rnd[23];
	end

	////////////////////
	// Protocol checks
	////////////////////

	assert property (@(posedge clk) disable iff (!rstn) bvalid |-> bresp == 2'b00)
	else report_error("bresp_zero", 0, bresp);
	assert property (@(posedge clk) disable iff (!rstn) rvalid |-> rresp == 2'b00)
	else report_error("rresp_zero", 0, rresp);
	assert property (@(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid)
	else report_error("b_hold", 1, bvalid);
	assert property (@(posedge clk) disable iff (!rstn)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else report_error("r_hold", 1, rvalid);
	assert property (@(posedge clk) disable iff (!rstn)
		dbg_we && dbg_rsp.stall |=> dbg_we && $stable(dbg_wr))
	else report_error("dbg_we_hold", 1, dbg_we);
	assert property (@(posedge clk) disable iff (!rstn)
		dbg_we && !dbg_rsp.stall |=> !dbg_we)
	else report_error("dbg_we_drop", 0, dbg_we);
	assert property (@(posedge clk) disable iff (!rstn) quiet_port |-> !dbg_we)
	else report_error("zero_strobe_quiet", 0, dbg_we);
	// START_HALTED clear, so a break resets the core
	assert property (@(posedge clk) disable iff (!rstn) brk |=> cpu_reset)
	else report_error("break_reset", 1, cpu_reset);
	assert property (@(posedge clk) disable iff (!rstn)
		clear_cache && cpu_halt && !dbg_rsp.stall |=> !clear_cache)
	else report_error("clear_cache_done", 0, clear_cache);

	// Hung run guard
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			fail_stop();
		end
	end

	////////////////////
	// Host tasks
	////////////////////

	task automatic axi_write(logic [7:0] addr, logic [31:0] data, logic [3:0] strb);
		@(posedge clk);
		#1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = addr;
		wbeat.data = data;
		wbeat.strb = strb;
		// AW and W leave together, both buffers are empty here
		@(posedge clk);
		while (!(awready && wready))
			@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(posedge clk);
		while (!(bvalid && bready))
			@(posedge clk);
	endtask

	task automatic axi_read(logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		arvalid = 1'b1;
		araddr = addr;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		// Address stays put, the core reads it straight through
		#1;
		arvalid = 1'b0;
		@(posedge clk);
		while (!(rvalid && rready))
			@(posedge clk);
		data = rdata;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		lcg_state = 32'hd217;
		{awvalid, wvalid, arvalid, interrupt, brk, quiet_port, stall_seen} = '0;
		{bready, rready, armed} = '0;
		awaddr = '0;
		araddr = '0;
		wbeat = '0;
		cc = '0;
		stall_left = 0;
		cycles = 0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;

		// 1: reset hold, then status
		wait (rstn);
		@(posedge clk);
		hold = 0;
		@(negedge clk);
		while (cpu_reset)
		begin
			hold++;
			@(negedge clk);
		end
		check_eq("reset_hold_len", `RESET_DURATION, hold);
		axi_read(8'h00, rd_val);
		check_eq("status_reset", 0, rd_val[`RESET_BIT]);
		check_eq("status_halt", START_HALTED, rd_val[`HALT_BIT]);

		// 2: halt, then release
		axi_write(CMD_ADDR, 32'h1 << `HALT_BIT, 4'b0010);
		axi_read(8'h00, rd_val);
		check_eq("halt_status", 1, rd_val[`HALT_BIT]);
		check_eq("halt_out", 1, cpu_halt);
		axi_write(CMD_ADDR, 32'h0, 4'b0010);
		axi_read(8'h00, rd_val);
		check_eq("release_status", 0, rd_val[`HALT_BIT]);
		check_eq("release_out", 0, cpu_halt);

		// 3: register writes until one has stalled, read back, zero strobe
		exp_reg = 5'd4;
		while (!stall_seen)
		begin
			exp_reg = exp_reg + 1'b1;
			exp_data = 32'ha5a5_1230 + exp_reg;
			reg_addr = {3'b000, exp_reg} << `DBG_LSB;
			axi_write(reg_addr, exp_data, 4'hf);
			wait (!dbg_we);
			@(negedge clk);
			check_eq("reg_write_halt", 1, cpu_halt);
			axi_read(CMD_ADDR | reg_addr, rd_val);
			check_eq("reg_readback", exp_data, rd_val);
			axi_read(8'h00, rd_val);
			check_eq("status_cc", exp_data[2:0], rd_val[14:12]);
		end
		quiet_port = 1'b1;
		axi_write(reg_addr, 32'hdead_beef, 4'h0);
		@(negedge clk);
		quiet_port = 1'b0;
		axi_read(CMD_ADDR | reg_addr, rd_val);
		check_eq("zero_strobe_keep", exp_data, rd_val);

		// 4: step pulses, then halted again
		fork
			axi_write(CMD_ADDR, 32'h1 << `STEP_BIT, 4'b0010);
			begin
				wait (cpu_step);
				@(negedge clk);
				while (cpu_step)
					@(negedge clk);
				check_eq("step_halt", 1, cpu_halt);
			end
		join

		// 5: clear cache with halt
		fork
			axi_write(CMD_ADDR, (32'h1 << `CLEAR_CACHE_BIT) | (32'h1 << `HALT_BIT), 4'b0010);
			begin
				wait (clear_cache);
				@(negedge clk);
				while (clear_cache)
					@(negedge clk);
				check_eq("clear_cache_halt", 1, cpu_halt);
			end
		join

		// 6: break from the core
		@(posedge clk);
		#1;
		brk = 1'b1;
		repeat (2)
			@(posedge clk);
		#1;
		brk = 1'b0;
		wait (!cpu_reset);
		axi_read(8'h00, rd_val);
		check_eq("break_cleared", 0, rd_val[`RESET_BIT]);

		$display("No errors");
		$finish;
	end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic	o_clk,
	output logic	o_rstn
);

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever
			#5 o_clk = ~o_clk;
	end

	// Reset low for 16 cycles, released just after an edge
	initial
	begin
		o_rstn = 1'b0;
		repeat (16)
			@(posedge o_clk);
		#1 o_rstn = 1'b1;
	end

endmodule

// ==== hw/zip_dbg_top.sv ====
`timescale 1ns/100ps
`include "dbg_consts.svh"

module zip_dbg_top #(
	parameter bit START_HALTED = 1'b0
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// Host side, byte addresses
	input  logic				i_awvalid,
	output logic				o_awready,
	input  logic [`DBG_ADDR_W-1:0]		i_awaddr,
	input  logic				i_wvalid,
	output logic				o_wready,
	input  dbg_bus_pkg::dbg_wbeat_t		i_wbeat,
	output logic				o_bvalid,
	input  logic				i_bready,
	output logic [1:0]			o_bresp,
	input  logic				i_arvalid,
	output logic				o_arready,
	input  logic [`DBG_ADDR_W-1:0]		i_araddr,
	output logic				o_rvalid,
	input  logic				i_rready,
	output logic [`DBG_DATA_W-1:0]		o_rdata,
	output logic [1:0]			o_rresp,
	// Core side
	input  logic				i_interrupt,
	input  cpu_ctl_pkg::cpu_dbg_rsp_t	i_dbg_rsp,
	input  logic [`DBG_DATA_W-1:0]		i_dbg_rdata,
	output logic				o_dbg_we,
	output cpu_ctl_pkg::cpu_dbg_wr_t	o_dbg_wr,
	output logic [`CPU_REG_W-1:0]		o_dbg_rreg,
	output logic				o_cpu_reset,
	output logic				o_cpu_halt,
	output logic				o_cpu_step,
	output logic				o_clear_cache
);
	import cpu_ctl_pkg::*;

	// Slave to controller
	ctl_status_t			status;
	dbg_wdata_u			cmd;
	logic				cmd_wr, reg_wr_taken;
	logic [`DBG_DATA_W/8-1:0]	cmd_strb;

	// Byte offset dropped on the way in
	dbg_axil_slave u_slave (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_awvalid	(i_awvalid),
		.o_awready	(o_awready),
		.i_awaddr	(i_awaddr[`DBG_ADDR_W-1:`DBG_LSB]),
		.i_wvalid	(i_wvalid),
		.o_wready	(o_wready),
		.i_wbeat	(i_wbeat),
		.o_bvalid	(o_bvalid),
		.i_bready	(i_bready),
		.o_bresp	(o_bresp),
		.i_arvalid	(i_arvalid),
		.o_arready	(o_arready),
		.i_araddr	(i_araddr[`DBG_ADDR_W-1:`DBG_LSB]),
		.o_rvalid	(o_rvalid),
		.i_rready	(i_rready),
		.o_rdata	(o_rdata),
		.o_rresp	(o_rresp),
		.i_status	(status),
		.i_dbg_rsp	(i_dbg_rsp),
		.i_dbg_rdata	(i_dbg_rdata),
		.o_dbg_we	(o_dbg_we),
		.o_dbg_wr	(o_dbg_wr),
		.o_dbg_rreg	(o_dbg_rreg),
		.o_cmd_wr	(cmd_wr),
		.o_cmd		(cmd),
		.o_cmd_strb	(cmd_strb),
		.o_reg_wr_taken	(reg_wr_taken)
	);

	cpu_cmd_ctrl #(.START_HALTED(START_HALTED)) u_ctrl (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_cmd_wr	(cmd_wr),
		.i_cmd		(cmd),
		.i_cmd_strb	(cmd_strb),
		.i_reg_wr_taken	(reg_wr_taken),
		.i_dbg_we	(o_dbg_we),
		.i_dbg_rsp	(i_dbg_rsp),
		.i_interrupt	(i_interrupt),
		.o_cpu_reset	(o_cpu_reset),
		.o_cpu_halt	(o_cpu_halt),
		.o_cpu_step	(o_cpu_step),
		.o_clear_cache	(o_clear_cache),
		.o_status	(status)
	);

endmodule

// ==== dbg_port/cpu_cmd_ctrl.sv ====
`timescale 1ns/100ps
`include "dbg_consts.svh"

module cpu_cmd_ctrl #(
	parameter bit START_HALTED = 1'b0
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// From the slave
	input  logic				i_cmd_wr,
	input  cpu_ctl_pkg::dbg_wdata_u		i_cmd,
	input  logic [`DBG_DATA_W/8-1:0]	i_cmd_strb,
	input  logic				i_reg_wr_taken,
	input  logic				i_dbg_we,
	// From the core
	input  cpu_ctl_pkg::cpu_dbg_rsp_t	i_dbg_rsp,
	input  logic				i_interrupt,
	// Commands
	output logic				o_cpu_reset,
	output logic				o_cpu_halt,
	output logic				o_cpu_step,
	output logic				o_clear_cache,
	output cpu_ctl_pkg::ctl_status_t	o_status
);
	import cpu_ctl_pkg::*;

	ctl_cmd_t	cmd;
	// Command writes that touch each strobe byte
	logic		rst_wr, ctl_wr;
	logic [$clog2(`RESET_DURATION+1)-1:0]	reset_counter;
	logic		reset_hold;

	assign cmd    = i_cmd.cmd;
	assign rst_wr = i_cmd_wr && i_cmd_strb[`RESET_BIT/8];
	assign ctl_wr = i_cmd_wr && i_cmd_strb[`HALT_BIT/8];

	////////////////////
	// Power-up reset hold
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			reset_counter <= `RESET_DURATION;
		else if (reset_counter > 0)
			reset_counter <= reset_counter - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			reset_hold <= 1'b1;
		else
			reset_hold <= (reset_counter > 1);
	end

	// Break resets the core unless it starts halted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || reset_hold)
			o_cpu_reset <= 1'b1;
		else if (i_dbg_rsp.brk && !START_HALTED)
			o_cpu_reset <= 1'b1;
		else
			o_cpu_reset <= rst_wr && cmd.reset;
	end

	////////////////////
	// Halt, step, clear cache
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cpu_halt <= START_HALTED;
		else if (o_cpu_reset && START_HALTED)
			o_cpu_halt <= START_HALTED;
		else
		begin
			// Release only with the core port quiet
			if (!i_dbg_we && !i_dbg_rsp.stall && ctl_wr && (!cmd.halt || cmd.step))
				o_cpu_halt <= 1'b0;
			// Later lines win over the release
			if (i_dbg_rsp.brk && START_HALTED)
				o_cpu_halt <= 1'b1;
			if (ctl_wr && cmd.halt && !cmd.step)
				o_cpu_halt <= 1'b1;
			if (i_reg_wr_taken)
				o_cpu_halt <= 1'b1;
			// Back to halt once a step is done
			if (o_cpu_step || o_clear_cache)
				o_cpu_halt <= 1'b1;
			if (ctl_wr && cmd.clear_cache)
				o_cpu_halt <= 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cpu_reset)
			o_clear_cache <= 1'b0;
		else if (ctl_wr && cmd.clear_cache && cmd.halt)
			o_clear_cache <= 1'b1;
		else if (o_cpu_halt && !i_dbg_rsp.stall)
			o_clear_cache <= 1'b0;
	end

	// Step lasts until the core accepts it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cpu_step <= 1'b0;
		else if (ctl_wr && cmd.step)
			o_cpu_step <= 1'b1;
		else if (!i_dbg_rsp.stall)
			o_cpu_step <= 1'b0;
	end

	// Status word, unused bits zero
	always_comb
	begin
		o_status             = '0;
		o_status.interrupt   = i_interrupt;
		o_status.brk         = i_dbg_rsp.brk;
		o_status.cc          = i_dbg_rsp.cc;
		o_status.halt        = o_cpu_halt;
		o_status.not_stalled = !i_dbg_rsp.stall;
		o_status.irq_pend    = i_interrupt;
		o_status.reset       = o_cpu_reset;
	end

endmodule

// ==== dbg_port/dbg_axil_slave.sv ====
`timescale 1ns/100ps
`include "dbg_consts.svh"

module dbg_axil_slave (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	// AW
	input  logic				i_awvalid,
	output logic				o_awready,
	input  dbg_bus_pkg::dbg_waddr_t		i_awaddr,
	// W
	input  logic				i_wvalid,
	output logic				o_wready,
	input  dbg_bus_pkg::dbg_wbeat_t		i_wbeat,
	// B
	output logic				o_bvalid,
	input  logic				i_bready,
	output logic [1:0]			o_bresp,
	// AR
	input  logic				i_arvalid,
	output logic				o_arready,
	input  dbg_bus_pkg::dbg_waddr_t		i_araddr,
	// R
	output logic				o_rvalid,
	input  logic				i_rready,
	output logic [`DBG_DATA_W-1:0]		o_rdata,
	output logic [1:0]			o_rresp,
	// Controller and core side
	input  cpu_ctl_pkg::ctl_status_t	i_status,
	input  cpu_ctl_pkg::cpu_dbg_rsp_t	i_dbg_rsp,
	input  logic [`DBG_DATA_W-1:0]		i_dbg_rdata,
	output logic				o_dbg_we,
	output cpu_ctl_pkg::cpu_dbg_wr_t	o_dbg_wr,
	output logic [`CPU_REG_W-1:0]		o_dbg_rreg,
	output logic				o_cmd_wr,
	output cpu_ctl_pkg::dbg_wdata_u		o_cmd,
	output logic [`DBG_DATA_W/8-1:0]	o_cmd_strb,
	output logic				o_reg_wr_taken
);
	import dbg_bus_pkg::*;

	// Skid buffer outputs
	logic		awskd_valid, wskd_valid, arskd_valid;
	dbg_waddr_t	awskd_addr, arskd_addr;
	dbg_wbeat_t	wskd_beat;

	logic		write_ready, read_ready;
	// Register read waiting on the core
	logic		read_pend;

	////////////////////
	// Write channels
	////////////////////

	dbg_skid_buffer #(.DW($bits(dbg_waddr_t))) u_awskd (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_awvalid),
		.o_ready	(o_awready),
		.i_data		(i_awaddr),
		.o_valid	(awskd_valid),
		.i_ready	(write_ready),
		.o_data		(awskd_addr)
	);

	dbg_skid_buffer #(.DW($bits(dbg_wbeat_t))) u_wskd (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_wvalid),
		.o_ready	(o_wready),
		.i_data		(i_wbeat),
		.o_valid	(wskd_valid),
		.i_ready	(write_ready),
		.o_data		(wskd_beat)
	);

	// Take a write once both halves are here and B is free
	// Register writes also wait for the core port to move
	assign write_ready = awskd_valid && wskd_valid
			&& ((wskd_beat.strb == '0) || awskd_addr.sel
				|| !i_dbg_rsp.stall || !o_dbg_we)
			&& (!o_bvalid || i_bready);

	// Core write port, held while the core stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_we <= 1'b0;
		else if (!o_dbg_we || !i_dbg_rsp.stall)
			o_dbg_we <= write_ready && (|wskd_beat.strb) && !awskd_addr.sel;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_dbg_we || !i_dbg_rsp.stall)
		begin
			o_dbg_wr.regno <= awskd_addr.regno;
			o_dbg_wr.data  <= wskd_beat.data;
		end
	end

	// Commands go out as a single-cycle strobe
	assign o_cmd_wr       = write_ready && awskd_addr.sel;
	assign o_cmd.raw      = wskd_beat.data;
	assign o_cmd_strb     = wskd_beat.strb;
	assign o_reg_wr_taken = write_ready && !awskd_addr.sel && (|wskd_beat.strb);

	// B follows every taken write, zero strobe included
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign o_bresp = 2'b00;

	////////////////////
	// Read channels
	////////////////////

	dbg_skid_buffer #(.DW($bits(dbg_waddr_t))) u_arskd (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_arvalid),
		.o_ready	(o_arready),
		.i_data		(i_araddr),
		.o_valid	(arskd_valid),
		.i_ready	(read_ready),
		.o_data		(arskd_addr)
	);

	assign read_ready = arskd_valid && !read_pend && (!o_rvalid || i_rready);

	// Core sees the register number straight away
	assign o_dbg_rreg = arskd_addr.regno;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			read_pend <= 1'b0;
		else
			read_pend <= read_ready && arskd_addr.sel;
	end

	// Status reads answer in one cycle, register reads in two
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && !arskd_addr.sel) || read_pend;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= read_pend ? i_dbg_rdata : i_status;
	end

	assign o_rresp = 2'b00;

endmodule

// ==== hw/dbg_skid_buffer.sv ====
`timescale 1ns/100ps

module dbg_skid_buffer #(
	parameter int DW = 8
) (
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	// Upstream
	input  logic		i_valid,
	output logic		o_ready,
	input  logic [DW-1:0]	i_data,
	// Downstream
	output logic		o_valid,
	input  logic		i_ready,
	output logic [DW-1:0]	o_data
);

	// Held word while downstream stalls
	logic		r_valid;
	logic [DW-1:0]	r_data;

	// Fill when a word comes in but cannot leave
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever passes while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Upstream ready is a register
	assign o_ready = !r_valid;

	// Pass-through when empty
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

// ==== common/cpu_ctl_pkg.sv ====
`include "dbg_consts.svh"

package cpu_ctl_pkg;

	////////////////////
	// Command and status words
	////////////////////

	// Command view of a debug write word
	// Only four bits carry meaning
	typedef struct packed
	{
		logic [`DBG_DATA_W-`CLEAR_CACHE_BIT-2:0]	rsvd_hi;
		logic						clear_cache;
		logic						halt;
		logic [`HALT_BIT-`STEP_BIT-2:0]			rsvd_mid;
		logic						step;
		logic [`STEP_BIT-`RESET_BIT-2:0]		rsvd_lo;
		logic						reset;
		logic [`RESET_BIT-1:0]				rsvd_reg;
	} ctl_cmd_t;

	// Same write word, decoded by the select bit
	typedef union packed
	{
		logic [`DBG_DATA_W-1:0]	raw;
		ctl_cmd_t		cmd;
	} dbg_wdata_u;

	// Status word returned on a read with select clear
	typedef struct packed
	{
		logic [14:0]	rsvd_hi;
		logic		interrupt;
		logic		brk;
		logic [2:0]	cc;
		logic		rsvd_11;
		logic		halt;
		logic		not_stalled;
		logic		rsvd_8;
		logic		irq_pend;
		logic		reset;
		logic [5:0]	rsvd_lo;
	} ctl_status_t;

	// Register write toward the core
	typedef struct packed
	{
		logic [`CPU_REG_W-1:0]	regno;
		logic [`DBG_DATA_W-1:0]	data;
	} cpu_dbg_wr_t;

	// Core debug response
	typedef struct packed
	{
		logic		stall;
		logic		brk;
		logic [2:0]	cc;
	} cpu_dbg_rsp_t;

endpackage

// ==== common/dbg_bus_pkg.sv ====
`include "dbg_consts.svh"

package dbg_bus_pkg;

	////////////////////
	// AXI-lite debug channels
	////////////////////

	// Word address after the byte offset is dropped
	// Select bit on top, register number below
	typedef struct packed
	{
		logic				sel;
		logic [`CPU_REG_W-1:0]		regno;
	} dbg_waddr_t;

	// W channel beat, data above strobes
	typedef struct packed
	{
		logic [`DBG_DATA_W-1:0]		data;
		logic [`DBG_DATA_W/8-1:0]	strb;
	} dbg_wbeat_t;

endpackage

// ==== common/dbg_consts.svh ====
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

////////////////////
// Debug bus layout
////////////////////

// Byte address width on the host side
`define DBG_ADDR_W	8
// Debug data word, fixed at 32
`define DBG_DATA_W	32
// Byte offset bits, dropped at the top level
`define DBG_LSB		2
// Word address bit that selects commands and CPU registers
`define CTL_SEL_BIT	5
// CPU register number width
`define CPU_REG_W	5

////////////////////
// Command word bits
////////////////////

// Strobe byte 0
`define RESET_BIT	6
// Strobe byte 1
`define STEP_BIT	8
`define HALT_BIT	10
`define CLEAR_CACHE_BIT	11

// Cycles of CPU reset after bus reset is released
`define RESET_DURATION	10

`endif
